//--- src.f
hw/issue_pkg.sv
hw/issue_queue.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/load_store_unit.sv
hw/data_mem.sv
hw/core_issue_top.sv
testbench/tb_core_issue.sv

//--- run.sh
#!/bin/sh
# Build and run the core issue testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module tb_core_issue -Mdir build -o sim_core_issue

./build/sim_core_issue | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
  exit 0
else
  exit 1
fi

//--- testbench/tb_core_issue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_issue;

  localparam int wait_limit = 200;

  logic clock = 1'b0;
  logic reset;
  logic clear;
  issue_pkg::uop_t in0;
  issue_pkg::uop_t in1;
  logic stall;
  issue_pkg::wb_t result0;
  issue_pkg::wb_t result1;

  logic [31:0] seed;
  logic [31:0] model_rf [16];
  logic [31:0] model_mem [64];
  logic [31:0] exp_val [256];
  logic [3:0] exp_addr [256];
  logic produces [256];
  logic seen [256];
  int res_cycle [256];
  int next_tag, want, got, last_tag, cycle, pairs_out;
  int value_errs, other_errs;
  logic stall_seen;

  core_issue_top i_dut (
    .clock(clock), .reset(reset), .clear(clear), .in0(in0), .in1(in1),
    .stall(stall), .result0(result0), .result1(result1)
  );

  always #10 clock = ~clock;

  // ==========================================================================
  // random numbers and the reference model
  // ==========================================================================

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic int pick(input int base, input int span);
    seed = xorshift(seed);
    return base + int'(seed[7:0]) % span;
  endfunction

  function automatic logic [15:0] rand16();
    seed = xorshift(seed);
    return seed[15:0];
  endfunction

  // builds one op with the next tag and runs it through the model in program order.
  function automatic issue_pkg::uop_t make_op(input issue_pkg::op_kind_t kind, input int rd,
                                              input int rs1, input int rs2,
                                              input logic [15:0] imm);
    issue_pkg::uop_t u;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sx;
    logic [31:0] r;
    logic [5:0] ad;
    u = issue_pkg::uop_none;
    u.valid = 1'b1;
    u.kind = kind;
    u.wren = rd > 0;
    u.waddr = rd[3:0];
    u.rden1 = 1'b1;
    u.raddr1 = rs1[3:0];
    u.rden2 = rs2 >= 0;
    u.raddr2 = rs2 >= 0 ? rs2[3:0] : 4'd0;
    u.imm = imm;
    u.tag = next_tag[7:0];
    sx = {{16{imm[15]}}, imm};
    a = model_rf[rs1];
    b = rs2 >= 0 ? model_rf[rs2] : sx;
    ad = 6'(a + sx);
    case (kind)
      issue_pkg::op_add: r = a + b;
      issue_pkg::op_sub: r = a - b;
      issue_pkg::op_and: r = a & b;
      issue_pkg::op_xor: r = a ^ b;
      issue_pkg::op_mul: r = a * b;
      issue_pkg::op_load: r = model_mem[ad];
      default: r = '0;
    endcase
    if (kind == issue_pkg::op_store) begin
      model_mem[ad] = b;
    end
    produces[next_tag] = rd > 0 && kind != issue_pkg::op_store && kind != issue_pkg::op_fence;
    seen[next_tag] = 1'b0;
    if (produces[next_tag]) begin
      model_rf[rd] = r;
      exp_val[next_tag] = r;
      exp_addr[next_tag] = rd[3:0];
      want++;
    end
    next_tag++;
    return u;
  endfunction

  // ==========================================================================
  // result monitor
  // ==========================================================================

  task automatic check_result(input issue_pkg::wb_t r, input string name);
    if (r.valid && (!produces[r.tag] || seen[r.tag])) begin
      $display("%s shows tag %0d, which is not an outstanding result", name, r.tag);
      other_errs++;
    end else if (r.valid) begin
      if (int'(r.tag) <= last_tag) begin
        $display("%s shows tag %0d after tag %0d, out of program order", name, r.tag,
                 last_tag);
        other_errs++;
      end
      if (r.wdata !== exp_val[r.tag]) begin
        $display("ERR %s.wdata tag %0d: expected 0x%h actual 0x%h", name, r.tag,
                 exp_val[r.tag], r.wdata);
        value_errs++;
      end
      if (r.waddr !== exp_addr[r.tag]) begin
        $display("ERR %s.waddr tag %0d: expected 0x%h actual 0x%h", name, r.tag,
                 exp_addr[r.tag], r.waddr);
        value_errs++;
      end
      seen[r.tag] = 1'b1;
      res_cycle[r.tag] = cycle;
      last_tag = int'(r.tag);
      got++;
    end
  endtask

  // result0 is checked first, so a pair must carry the older tag on result0.
  always @(negedge clock) begin
    cycle++;
    if (reset) begin
      if (stall) stall_seen = 1'b1;
      if (result0.valid && result1.valid) pairs_out++;
      check_result(result0, "result0");
      check_result(result1, "result1");
    end
  end

  // ==========================================================================
  // stimulus helpers
  // ==========================================================================

  task automatic send(input issue_pkg::uop_t a, input issue_pkg::uop_t b);
    int n;
    in0 = a;
    in1 = b;
    n = 0;
    while (stall && n < wait_limit) begin
      @(negedge clock);
      n++;
    end
    if (stall) begin
      $display("stall stayed high while offering tag %0d", a.tag);
      other_errs++;
    end
    @(negedge clock);                 // accepted at the edge just passed.
  endtask

  task automatic idle();
    in0 = issue_pkg::uop_none;
    in1 = issue_pkg::uop_none;
  endtask

  task automatic wait_all();
    int n;
    n = 0;
    while (got < want && n < wait_limit) begin
      @(negedge clock);
      n++;
    end
    if (got < want) begin
      $display("timed out with %0d results still missing", want - got);
      other_errs++;
    end
  endtask

  task automatic check_all_seen(input int first, input int last);
    for (int t = first; t <= last; t++) begin
      if (produces[t] && !seen[t]) begin
        $display("tag %0d never produced its result", t);
        other_errs++;
      end
    end
  endtask

  task automatic check_apart(input int t0, input int t1);
    if (res_cycle[t0] == res_cycle[t1]) begin
      $display("tags %0d and %0d completed together although they may not pair", t0, t1);
      other_errs++;
    end
  endtask

  // pairs of loads never pair, so the queue backs up until stall rises.
  task automatic fill_with_loads();
    issue_pkg::uop_t a;
    issue_pkg::uop_t b;
    int n;
    for (int i = 0; i < 4; i++) begin
      a = make_op(issue_pkg::op_load, 1 + i, 0, -1, {10'd0, 6'(pick(0, 64))});
      b = make_op(issue_pkg::op_load, 5 + i, 0, -1, {10'd0, 6'(pick(0, 64))});
      send(a, b);
    end
    idle();
    n = 0;
    while (!stall && n < wait_limit) begin
      @(negedge clock);
      n++;
    end
    if (!stall) begin
      $display("stall never rose behind the queued loads");
      other_errs++;
    end
  endtask

  // ==========================================================================
  // directed tests
  // ==========================================================================

  task automatic test_alu_pairs();
    issue_pkg::uop_t a;
    issue_pkg::uop_t b;
    int t0;
    int p0;
    t0 = next_tag;
    for (int i = 0; i < 7; i++) begin
      a = make_op(issue_pkg::op_add, 2 * i + 1, 0, -1, rand16());
      b = make_op(issue_pkg::op_add, 2 * i + 2, 0, -1, rand16());
      send(a, b);
    end
    a = make_op(issue_pkg::op_add, 15, 0, -1, rand16());
    send(a, issue_pkg::uop_none);
    p0 = pairs_out;
    for (int i = 0; i < 10; i++) begin
      a = make_op(issue_pkg::op_kind_t'(3'(pick(0, 4))), pick(1, 4), pick(9, 3),
                  pick(0, 2) == 0 ? 12 : -1, rand16());
      b = make_op(issue_pkg::op_kind_t'(3'(pick(0, 4))), pick(5, 4), pick(13, 3),
                  pick(0, 2) == 0 ? 12 : -1, rand16());
      send(a, b);
    end
    idle();
    wait_all();
    check_all_seen(t0, next_tag - 1);
    if (pairs_out == p0) begin
      $display("no pair of independent ALU ops completed together");
      other_errs++;
    end
  endtask

  task automatic test_pairing();
    issue_pkg::uop_t a;
    issue_pkg::uop_t b;
    int t0;
    t0 = next_tag;
    a = make_op(issue_pkg::op_add, 1, 9, -1, 16'd3);     // raw pair lands behind it.
    send(a, issue_pkg::uop_none);
    a = make_op(issue_pkg::op_xor, 5, 10, 11, 16'd0);
    b = make_op(issue_pkg::op_sub, 6, 5, 12, 16'd0);
    send(a, b);
    a = make_op(issue_pkg::op_add, 2, 9, -1, 16'd5);
    send(a, issue_pkg::uop_none);
    a = make_op(issue_pkg::op_mul, 7, 13, 14, 16'd0);
    b = make_op(issue_pkg::op_mul, 8, 14, 15, 16'd0);
    send(a, b);
    a = make_op(issue_pkg::op_and, 3, 10, 11, 16'd0);
    b = make_op(issue_pkg::op_fence, 0, 0, -1, 16'd0);
    send(a, b);
    a = make_op(issue_pkg::op_add, 4, 9, -1, 16'd7);
    send(a, issue_pkg::uop_none);
    idle();
    wait_all();
    check_all_seen(t0, next_tag - 1);
    check_apart(t0 + 1, t0 + 2);
    check_apart(t0 + 4, t0 + 5);
    check_apart(t0 + 6, t0 + 8);
  endtask

  task automatic test_mem();
    issue_pkg::uop_t a;
    issue_pkg::uop_t b;
    logic [5:0] addr [4];
    int t0;
    t0 = next_tag;
    for (int i = 0; i < 4; i++) begin
      addr[i] = 6'(16 * i + pick(0, 16));
      a = make_op(issue_pkg::op_add, 9 + i, 0, -1, rand16());
      b = make_op(issue_pkg::op_store, 0, 0, 9 + i, {10'd0, addr[i]});
      send(a, b);
    end
    for (int i = 0; i < 4; i++) begin
      a = make_op(issue_pkg::op_load, 1 + i, 0, -1, {10'd0, addr[i]});
      b = make_op(issue_pkg::op_add, 5 + i, 1 + i, -1, 16'd3);
      send(a, b);
    end
    a = make_op(issue_pkg::op_xor, 13, 14, 15, 16'd0);  // load in the second slot.
    b = make_op(issue_pkg::op_load, 14, 0, -1, {10'd0, addr[0]});
    send(a, b);
    idle();
    wait_all();
    check_all_seen(t0, next_tag - 1);
  endtask

  task automatic test_backpressure();
    issue_pkg::uop_t a;
    issue_pkg::uop_t b;
    int t0;
    t0 = next_tag;
    stall_seen = 1'b0;
    for (int i = 0; i < 6; i++) begin
      a = make_op(issue_pkg::op_load, 1 + i, 0, -1, {10'd0, 6'(pick(0, 64))});
      b = make_op(issue_pkg::op_add, 7 + i, 13, 1 + i, 16'd0);
      send(a, b);
    end
    idle();
    wait_all();
    check_all_seen(t0, next_tag - 1);
    if (!stall_seen) begin
      $display("stall never rose behind the load chain");
      other_errs++;
    end
    if (stall) begin
      $display("stall is still high after the queue drained");
      other_errs++;
    end
  endtask

  task automatic test_clear();
    int t0;
    int dropped;
    logic gap;
    t0 = next_tag;
    fill_with_loads();
    clear = 1'b1;
    @(negedge clock);
    clear = 1'b0;
    repeat (40) @(negedge clock);    // lets the load in flight finish.
    gap = 1'b0;
    dropped = 0;
    for (int t = t0; t < next_tag; t++) begin
      if (!seen[t]) begin
        gap = 1'b1;
        dropped++;
        if (produces[t]) want--;
        produces[t] = 1'b0;
      end else if (gap) begin
        $display("tag %0d appeared although an older queued op was cleared", t);
        other_errs++;
      end
    end
    if (dropped == 0) begin
      $display("clear removed no op from a stalled queue");
      other_errs++;
    end
  endtask

  task automatic test_reset();
    fill_with_loads();
    reset = 1'b0;
    repeat (3) @(negedge clock);
    if (stall !== 1'b0) begin
      $display("ERR stall: expected 0x0 actual 0x%h", stall);
      value_errs++;
    end
    if (result0.valid !== 1'b0) begin
      $display("ERR result0.valid: expected 0x0 actual 0x%h", result0.valid);
      value_errs++;
    end
    if (result1.valid !== 1'b0) begin
      $display("ERR result1.valid: expected 0x0 actual 0x%h", result1.valid);
      value_errs++;
    end
    reset = 1'b1;
    @(negedge clock);
  endtask

  initial begin
    reset = 1'b0;
    clear = 1'b0;
    in0 = issue_pkg::uop_none;
    in1 = issue_pkg::uop_none;
    seed = 32'h6966c36b;
    next_tag = 0;
    want = 0;
    got = 0;
    last_tag = -1;
    cycle = 0;
    pairs_out = 0;
    value_errs = 0;
    other_errs = 0;
    stall_seen = 1'b0;
    for (int i = 0; i < 16; i++) model_rf[i] = '0;
    for (int i = 0; i < 64; i++) model_mem[i] = '0;
    for (int i = 0; i < 256; i++) begin
      produces[i] = 1'b0;
      seen[i] = 1'b0;
      res_cycle[i] = -1;
    end
    repeat (3) @(negedge clock);
    reset = 1'b1;
    test_alu_pairs();
    test_pairing();
    test_mem();
    test_backpressure();
    test_clear();
    test_reset();
    $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/core_issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_issue_top (
  input  wire logic clock,
  input  wire logic reset,
  input  wire logic clear,
  input  wire issue_pkg::uop_t in0,
  input  wire issue_pkg::uop_t in1,
  output logic stall,
  output issue_pkg::wb_t result0,
  output issue_pkg::wb_t result1
);

  issue_pkg::issue_t issue;
  issue_pkg::mem_req_t mem_req;
  issue_pkg::wb_t lsu_wb;
  issue_pkg::apb_req_t apb_req;
  issue_pkg::apb_rsp_t apb_rsp;
  logic busy;

  logic [issue_pkg::reg_addr_w-1:0] raddr0a, raddr0b, raddr1a, raddr1b;
  logic [issue_pkg::data_w-1:0] rdata0a, rdata0b, rdata1a, rdata1b;

  issue_queue i_queue (
    .clock(clock), .reset(reset),
    .in0(in0), .in1(in1), .clear(clear), .busy(busy),
    .issue(issue), .stall(stall)
  );

  // results go to the ports and to the register file write ports.
  reg_file i_regs (
    .clock(clock), .reset(reset),
    .raddr0a(raddr0a), .raddr0b(raddr0b), .raddr1a(raddr1a), .raddr1b(raddr1b),
    .rdata0a(rdata0a), .rdata0b(rdata0b), .rdata1a(rdata1a), .rdata1b(rdata1b),
    .wb0(result0), .wb1(result1)
  );

  exec_unit i_exec (
    .clock(clock), .reset(reset), .issue(issue),
    .raddr0a(raddr0a), .raddr0b(raddr0b), .raddr1a(raddr1a), .raddr1b(raddr1b),
    .rdata0a(rdata0a), .rdata0b(rdata0b), .rdata1a(rdata1a), .rdata1b(rdata1b),
    .mem_req(mem_req), .lsu_wb(lsu_wb), .lsu_busy(busy),
    .wb0(result0), .wb1(result1)
  );

  load_store_unit i_lsu (
    .clock(clock), .reset(reset),
    .mem_req(mem_req), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .busy(busy), .lsu_wb(lsu_wb)
  );

  data_mem i_mem (
    .clock(clock), .reset(reset),
    .apb_req(apb_req), .apb_rsp(apb_rsp)
  );

endmodule

`default_nettype wire

//--- hw/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
  parameter int unsigned wait_states = 2
) (
  input  wire logic clock,
  input  wire logic reset,
  input  wire issue_pkg::apb_req_t apb_req,
  output issue_pkg::apb_rsp_t apb_rsp
);

  logic [issue_pkg::data_w-1:0] mem [2**issue_pkg::mem_addr_w];
  int unsigned wait_cnt;
  logic access;

  assign access = apb_req.psel && apb_req.penable;

  always_comb begin
    apb_rsp.pready = access && wait_cnt == wait_states;
    apb_rsp.prdata = mem[apb_req.paddr];
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      wait_cnt <= 0;
      for (int i = 0; i < 2**issue_pkg::mem_addr_w; i++) begin
        mem[i] <= '0;
      end
    end else begin
      wait_cnt <= (access && !apb_rsp.pready) ? wait_cnt + 1 : 0;
      if (access && apb_rsp.pready && apb_req.pwrite) begin
        mem[apb_req.paddr] <= apb_req.pwdata;   // write lands at completion.
      end
    end
  end

  a_apb_hold: assert property (@(posedge clock) disable iff (!reset)
    access && !apb_rsp.pready |=> apb_req.penable && $stable(apb_req.paddr) &&
                                  $stable(apb_req.pwdata));

endmodule

`default_nettype wire

//--- hw/load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
  input  wire logic clock,
  input  wire logic reset,
  input  wire issue_pkg::mem_req_t mem_req,
  output issue_pkg::apb_req_t apb_req,
  input  wire issue_pkg::apb_rsp_t apb_rsp,
  output logic busy,
  output issue_pkg::wb_t lsu_wb
);

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access
  } state_t;

  state_t state;
  issue_pkg::mem_req_t req_q;
  logic done;

  assign done = state == st_access && apb_rsp.pready;
  assign busy = state != st_idle;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:   if (mem_req.valid) state <= st_setup;
        st_setup:  state <= st_access;
        st_access: if (apb_rsp.pready) state <= st_idle;
        default:   state <= st_idle;
      endcase
    end
  end

  // address and data stay put from setup until the transfer completes.
  always_ff @(posedge clock) begin
    if (state == st_idle && mem_req.valid) begin
      req_q <= mem_req;
    end
  end

  always_comb begin
    apb_req.psel = state != st_idle;
    apb_req.penable = state == st_access;
    apb_req.pwrite = req_q.write;
    apb_req.paddr = req_q.addr;
    apb_req.pwdata = req_q.wdata;
  end

  always_ff @(posedge clock) begin
    lsu_wb.valid <= done && !req_q.write;    // stores complete without a result.
    lsu_wb.waddr <= req_q.waddr;
    lsu_wb.wdata <= apb_rsp.prdata;
    lsu_wb.tag <= req_q.tag;
    if (!reset) begin
      lsu_wb.valid <= 1'b0;
    end
  end

  a_no_overlap: assert property (@(posedge clock) disable iff (!reset)
    mem_req.valid |-> !busy);

endmodule

`default_nettype wire

//--- hw/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
  input  wire logic clock,
  input  wire logic reset,
  input  wire issue_pkg::issue_t issue,
  output logic [issue_pkg::reg_addr_w-1:0] raddr0a,
  output logic [issue_pkg::reg_addr_w-1:0] raddr0b,
  output logic [issue_pkg::reg_addr_w-1:0] raddr1a,
  output logic [issue_pkg::reg_addr_w-1:0] raddr1b,
  input  wire logic [issue_pkg::data_w-1:0] rdata0a,
  input  wire logic [issue_pkg::data_w-1:0] rdata0b,
  input  wire logic [issue_pkg::data_w-1:0] rdata1a,
  input  wire logic [issue_pkg::data_w-1:0] rdata1b,
  output issue_pkg::mem_req_t mem_req,
  input  wire issue_pkg::wb_t lsu_wb,
  input  wire logic lsu_busy,
  output issue_pkg::wb_t wb0,
  output issue_pkg::wb_t wb1
);

  logic [issue_pkg::data_w-1:0] opb0, opb1, mul_a, mul_b, mul_p, addr_sum;
  logic mul_on_1, mem_on_1;
  issue_pkg::uop_t mem_uop;
  issue_pkg::wb_t lane0_d, lane1_d, lane0_q, lane1_q;

  function automatic logic [issue_pkg::data_w-1:0] sext(input logic [15:0] imm);
    return {{(issue_pkg::data_w-16){imm[15]}}, imm};
  endfunction

  function automatic logic [issue_pkg::data_w-1:0] alu(
    input issue_pkg::op_kind_t kind,
    input logic [issue_pkg::data_w-1:0] a,
    input logic [issue_pkg::data_w-1:0] b
  );
    case (kind)
      issue_pkg::op_sub: return a - b;
      issue_pkg::op_and: return a & b;
      issue_pkg::op_xor: return a ^ b;
      default: return a + b;
    endcase
  endfunction

  function automatic logic writes_lane(input issue_pkg::uop_t u);
    return u.valid && u.wren && u.kind inside {issue_pkg::op_add, issue_pkg::op_sub,
      issue_pkg::op_and, issue_pkg::op_xor, issue_pkg::op_mul};
  endfunction

  assign raddr0a = issue.slot0.raddr1;
  assign raddr0b = issue.slot0.raddr2;
  assign raddr1a = issue.slot1.raddr1;
  assign raddr1b = issue.slot1.raddr2;

  assign opb0 = issue.slot0.rden2 ? rdata0b : sext(issue.slot0.imm);
  assign opb1 = issue.slot1.rden2 ? rdata1b : sext(issue.slot1.imm);

  // one multiplier, steered to the slot that holds the multiply.
  assign mul_on_1 = issue.slot1.valid && issue.slot1.kind == issue_pkg::op_mul;
  assign mul_a = mul_on_1 ? rdata1a : rdata0a;
  assign mul_b = mul_on_1 ? opb1 : opb0;
  assign mul_p = mul_a * mul_b;

  // ==========================================================================
  // memory op routing
  // ==========================================================================

  assign mem_on_1 = issue.slot1.valid && issue.slot1.kind inside {issue_pkg::op_load,
    issue_pkg::op_store};
  assign mem_uop = mem_on_1 ? issue.slot1 : issue.slot0;
  assign addr_sum = (mem_on_1 ? rdata1a : rdata0a) + sext(mem_uop.imm);

  always_comb begin
    mem_req.valid = mem_uop.valid && !lsu_busy &&
                    mem_uop.kind inside {issue_pkg::op_load, issue_pkg::op_store};
    mem_req.write = mem_uop.kind == issue_pkg::op_store;
    mem_req.addr = addr_sum[issue_pkg::mem_addr_w-1:0];
    mem_req.wdata = mem_on_1 ? rdata1b : rdata0b;    // store data is rs2.
    mem_req.waddr = mem_uop.waddr;
    mem_req.tag = mem_uop.tag;
  end

  // ==========================================================================
  // writeback
  // ==========================================================================

  always_comb begin
    lane0_d.valid = writes_lane(issue.slot0);
    lane0_d.waddr = issue.slot0.waddr;
    lane0_d.wdata = issue.slot0.kind == issue_pkg::op_mul ? mul_p :
                    alu(issue.slot0.kind, rdata0a, opb0);
    lane0_d.tag = issue.slot0.tag;
    lane1_d.valid = writes_lane(issue.slot1);
    lane1_d.waddr = issue.slot1.waddr;
    lane1_d.wdata = issue.slot1.kind == issue_pkg::op_mul ? mul_p :
                    alu(issue.slot1.kind, rdata1a, opb1);
    lane1_d.tag = issue.slot1.tag;
  end

  always_ff @(posedge clock) begin
    lane0_q <= lane0_d;
    lane1_q <= lane1_d;
    if (!reset) begin
      lane0_q.valid <= 1'b0;
      lane1_q.valid <= 1'b0;
    end
  end

  always_comb begin
    wb0 = lane0_q;
    wb1 = lane1_q;
    if (lsu_wb.valid) begin
      if (!lane1_q.valid) begin
        wb1 = lsu_wb;             // lane 1 is the preferred home for a load.
      end else begin
        wb0 = lsu_wb;
      end
    end
  end

  a_one_mul: assert property (@(posedge clock) disable iff (!reset)
    !(issue.slot0.kind == issue_pkg::op_mul && mul_on_1 && issue.slot0.valid));

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire logic clock,
  input  wire logic reset,
  input  wire logic [issue_pkg::reg_addr_w-1:0] raddr0a,
  input  wire logic [issue_pkg::reg_addr_w-1:0] raddr0b,
  input  wire logic [issue_pkg::reg_addr_w-1:0] raddr1a,
  input  wire logic [issue_pkg::reg_addr_w-1:0] raddr1b,
  output logic [issue_pkg::data_w-1:0] rdata0a,
  output logic [issue_pkg::data_w-1:0] rdata0b,
  output logic [issue_pkg::data_w-1:0] rdata1a,
  output logic [issue_pkg::data_w-1:0] rdata1b,
  input  wire issue_pkg::wb_t wb0,
  input  wire issue_pkg::wb_t wb1
);

  logic [issue_pkg::data_w-1:0] regs [2**issue_pkg::reg_addr_w];

  // writes of this cycle are visible to ops issued in the same cycle.
  function automatic logic [issue_pkg::data_w-1:0] read_reg(
    input logic [issue_pkg::reg_addr_w-1:0] addr
  );
    if (addr == '0) begin
      return '0;
    end
    if (wb1.valid && wb1.waddr == addr) begin
      return wb1.wdata;
    end
    if (wb0.valid && wb0.waddr == addr) begin
      return wb0.wdata;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rdata0a = read_reg(raddr0a);
    rdata0b = read_reg(raddr0b);
    rdata1a = read_reg(raddr1a);
    rdata1b = read_reg(raddr1b);
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < 2**issue_pkg::reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wb0.valid) begin
        regs[wb0.waddr] <= wb0.wdata;
      end
      if (wb1.valid) begin
        regs[wb1.waddr] <= wb1.wdata;   // younger op wins a shared target.
      end
    end
  end

  a_no_double_write: assert property (@(posedge clock) disable iff (!reset)
    !(wb0.valid && wb1.valid && wb0.waddr == wb1.waddr && wb0.waddr != '0));

endmodule

`default_nettype wire

//--- hw/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue (
  input  wire logic clock,
  input  wire logic reset,
  input  wire issue_pkg::uop_t in0,
  input  wire issue_pkg::uop_t in1,
  input  wire logic clear,
  input  wire logic busy,
  output issue_pkg::issue_t issue,
  output logic stall
);

  issue_pkg::uop_t buffer [issue_pkg::queue_depth];

  logic [issue_pkg::queue_ptr_w-1:0] rd_ptr;
  logic [issue_pkg::queue_ptr_w-1:0] rd_ptr1;
  logic [issue_pkg::queue_ptr_w-1:0] wr_ptr;
  logic [issue_pkg::queue_ptr_w-1:0] wr_ptr1;
  logic [issue_pkg::queue_ptr_w:0] count;
  logic [issue_pkg::queue_ptr_w:0] count_next;
  logic [issue_pkg::queue_ptr_w:0] pass;
  logic [issue_pkg::queue_ptr_w:0] n_push;

  issue_pkg::uop_t head0;
  issue_pkg::uop_t head1;
  logic accept0;
  logic accept1;
  logic single;
  logic conflict;
  logic depend;

  function automatic logic is_mem(input issue_pkg::op_kind_t kind);
    return kind == issue_pkg::op_load || kind == issue_pkg::op_store;
  endfunction

  // ==========================================================================
  // ring buffer write side
  // ==========================================================================

  assign accept0 = !stall && in0.valid;
  assign accept1 = !stall && in1.valid;

  assign wr_ptr1 = wr_ptr + {{(issue_pkg::queue_ptr_w-1){1'b0}}, accept0};
  assign n_push = {{issue_pkg::queue_ptr_w{1'b0}}, accept0} +
                  {{issue_pkg::queue_ptr_w{1'b0}}, accept1};

  always_ff @(posedge clock) begin
    if (accept0) begin
      buffer[wr_ptr] <= in0;
    end
    if (accept1) begin
      buffer[wr_ptr1] <= in1;       // lands behind in0 when both arrive.
    end
  end

  // ==========================================================================
  // pairing and hazards on the two oldest entries
  // ==========================================================================

  assign rd_ptr1 = rd_ptr + {{(issue_pkg::queue_ptr_w-1){1'b0}}, 1'b1};
  assign head0 = buffer[rd_ptr];
  assign head1 = buffer[rd_ptr1];

  always_comb begin
    // a load in slot 0 goes alone so that nothing younger completes first.
    single = head0.kind == issue_pkg::op_fence || head1.kind == issue_pkg::op_fence ||
             head0.kind == issue_pkg::op_load;

    conflict = (head0.kind == issue_pkg::op_mul && head1.kind == issue_pkg::op_mul) ||
               (is_mem(head0.kind) && is_mem(head1.kind));

    depend = 1'b0;
    if (head0.wren && head0.waddr != '0) begin
      if (head1.rden1 && head1.raddr1 == head0.waddr) begin
        depend = 1'b1;
      end
      if (head1.rden2 && head1.raddr2 == head0.waddr) begin
        depend = 1'b1;
      end
      if (head1.wren && head1.waddr == head0.waddr) begin
        depend = 1'b1;              // both writes would land in the same cycle.
      end
    end

    if (single || conflict || depend) begin
      pass = 1;
    end else begin
      pass = 2;
    end
    if (busy) begin
      pass = 0;
    end
    if (count < pass) begin
      pass = count;
    end
  end

  always_comb begin
    issue.slot0 = pass > 0 ? head0 : issue_pkg::uop_none;
    issue.slot1 = pass > 1 ? head1 : issue_pkg::uop_none;
  end

  assign count_next = count - pass + n_push;

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count <= '0;
      stall <= 1'b0;
    end else begin
      rd_ptr <= rd_ptr + pass[issue_pkg::queue_ptr_w-1:0];
      wr_ptr <= wr_ptr + n_push[issue_pkg::queue_ptr_w-1:0];
      count <= count_next;
      stall <= count_next > issue_pkg::stall_level;
    end
  end

  // ==========================================================================
  // assertions
  // ==========================================================================

  a_count_bound: assert property (@(posedge clock) disable iff (!reset)
    count <= issue_pkg::queue_depth);

  a_slot_order: assert property (@(posedge clock) disable iff (!reset)
    issue.slot1.valid |-> issue.slot0.valid);

  a_busy_hold: assert property (@(posedge clock) disable iff (!reset)
    busy |-> !issue.slot0.valid && !issue.slot1.valid);

endmodule

`default_nettype wire

//--- hw/issue_pkg.sv
`default_nettype none

package issue_pkg;

  // ==========================================================================
  // sizing
  // ==========================================================================

  localparam int queue_depth = 8;
  localparam int queue_ptr_w = 3;
  localparam int stall_level = 4;     // input stalls while more entries than this remain.

  localparam int reg_addr_w = 4;
  localparam int data_w = 32;
  localparam int mem_addr_w = 6;      // word address into the data memory.

  // ==========================================================================
  // micro-ops and results
  // ==========================================================================

  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_and,
    op_xor,
    op_mul,
    op_load,
    op_store,
    op_fence
  } op_kind_t;

  typedef struct packed {
    logic valid;
    op_kind_t kind;
    logic wren;
    logic [reg_addr_w-1:0] waddr;
    logic rden1;
    logic [reg_addr_w-1:0] raddr1;
    logic rden2;
    logic [reg_addr_w-1:0] raddr2;
    logic [15:0] imm;                 // sign extended by the execute unit.
    logic [7:0] tag;
  } uop_t;

  typedef struct packed {
    uop_t slot0;
    uop_t slot1;                      // only valid together with slot0.
  } issue_t;

  typedef struct packed {
    logic valid;
    logic [reg_addr_w-1:0] waddr;
    logic [data_w-1:0] wdata;
    logic [7:0] tag;
  } wb_t;

  typedef struct packed {
    logic valid;
    logic write;
    logic [mem_addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic [reg_addr_w-1:0] waddr;     // load destination register.
    logic [7:0] tag;
  } mem_req_t;

  // ==========================================================================
  // APB
  // ==========================================================================

  typedef struct packed {
    logic psel;
    logic penable;
    logic pwrite;
    logic [mem_addr_w-1:0] paddr;
    logic [data_w-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic pready;
    logic [data_w-1:0] prdata;
  } apb_rsp_t;

  localparam uop_t uop_none = '0;
  localparam wb_t wb_none = '0;

endpackage

`default_nettype wire
